//--- hw/snd_bus_pkg.sv
/*
  Shared types and constants for the sound CPU I/O bus.
  The scramble table covers exactly four chip ports, so NUM_PORTS is fixed here.
  Select 2 steps the scramble counter and select 5 clears it.
*/
package snd_bus_pkg;

    // meaningful widths of the I/O window
    typedef logic [2:0] sel_t;
    typedef logic [1:0] reg_idx_t;
    typedef logic [7:0] data_t;
    typedef logic [1:0] scram_t;

    // 0 FM-A, 1 FM-B, 2 ADPCM, 3 latch
    typedef logic [1:0] port_id_t;

    localparam int NUM_PORTS = 4;

    // control selects, never routed to a port
    localparam sel_t SEL_COUNT = 3'd2;
    localparam sel_t SEL_CLEAR = 3'd5;

    // value returned for unmapped and control reads
    localparam data_t OPEN_BUS = 8'hff;

    // host request, 14 bits
    typedef struct packed {
        logic     wr;
        sel_t     sel;
        reg_idx_t idx;
        data_t    wdata;
    } bus_req_t;

    // read response
    typedef struct packed {
        data_t rdata;
    } bus_rsp_t;

    // one-cycle access strobe toward a single chip port
    typedef struct packed {
        logic     valid;
        logic     wr;
        reg_idx_t idx;
        data_t    wdata;
    } port_acc_t;

endpackage

//--- hw/snd_bus_top.sv
/*
  Sound bus I/O top: request FIFO, select decoder, four chip ports and merger.
  A read popped in cycle p responds in cycle p+3; credit_ret follows each pop by one cycle.
  The host must keep within FIFO_DEPTH outstanding credits.
*/
`timescale 1ns/1ps

module snd_bus_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  snd_bus_pkg::bus_req_t req,
    output logic                  credit_ret,
    output logic                  rsp_valid,
    output snd_bus_pkg::bus_rsp_t rsp
);

    logic                   pop_valid;
    snd_bus_pkg::bus_req_t  pop_req;
    snd_bus_pkg::port_acc_t port_acc [snd_bus_pkg::NUM_PORTS];
    logic                   rd_pend_valid;
    snd_bus_pkg::port_id_t  rd_pend_port;
    logic                   rd_pend_unmapped;
    snd_bus_pkg::data_t     rd_data [snd_bus_pkg::NUM_PORTS];

    snd_req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_req_fifo (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .pop_valid  (pop_valid),
        .pop_req    (pop_req),
        .credit_ret (credit_ret)
    );

    snd_sel_decode u_sel_decode (
        .clk              (clk),
        .rst              (rst),
        .pop_valid        (pop_valid),
        .pop_req          (pop_req),
        .port_acc         (port_acc),
        .rd_pend_valid    (rd_pend_valid),
        .rd_pend_port     (rd_pend_port),
        .rd_pend_unmapped (rd_pend_unmapped)
    );

    // ports 0..3 stand for FM-A, FM-B, ADPCM and latch
    for (genvar i = 0; i < snd_bus_pkg::NUM_PORTS; i++) begin : g_port
        snd_chip_port u_chip_port (
            .clk     (clk),
            .rst     (rst),
            .acc     (port_acc[i]),
            .rd_data (rd_data[i])
        );
    end

    snd_rsp_merge u_rsp_merge (
        .clk              (clk),
        .rst              (rst),
        .rd_pend_valid    (rd_pend_valid),
        .rd_pend_port     (rd_pend_port),
        .rd_pend_unmapped (rd_pend_unmapped),
        .rd_data          (rd_data),
        .rsp_valid        (rsp_valid),
        .rsp              (rsp)
    );

endmodule

//--- hw/snd_chip_port.sv
/*
  Generic chip port: four 8-bit registers, cleared by reset.
  A write lands at the clock after the strobe.
  Read data appears on rd_data one cycle after a read strobe and holds until the next read.
*/
`timescale 1ns/1ps

module snd_chip_port (
    input  logic                   clk,
    input  logic                   rst,
    input  snd_bus_pkg::port_acc_t acc,
    output snd_bus_pkg::data_t     rd_data
);

    localparam int NUM_REGS = 4;

    snd_bus_pkg::data_t regs [NUM_REGS];
    logic               wr_en;
    logic               rd_en;

    assign wr_en = acc.valid && acc.wr;
    assign rd_en = acc.valid && !acc.wr;

    // register bank
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en) begin
            regs[acc.idx] <= acc.wdata;
        end
    end

    // registered read of the addressed byte
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= regs[acc.idx];
        end
    end

endmodule

//--- hw/snd_req_fifo.sv
/*
  Credit-backed request queue. The host starts with FIFO_DEPTH credits.
  The head pops every cycle it is non-empty, since the decoder never stalls.
  Each pop returns one credit through a registered pulse on credit_ret.
*/
`timescale 1ns/1ps

module snd_req_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  snd_bus_pkg::bus_req_t req,
    output logic                  pop_valid,
    output snd_bus_pkg::bus_req_t pop_req,
    output logic                  credit_ret
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(FIFO_DEPTH - 1);

    snd_bus_pkg::bus_req_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST_IDX) ? '0 : ptr + 1'b1;
    endfunction

    // when full the head always leaves in the same cycle, so a push never overflows
    assign pop       = (count != '0);
    assign pop_valid = pop;
    assign pop_req   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (req_valid) begin
            mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            credit_ret <= pop;
            if (req_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({req_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/snd_rsp_merge.sv
/*
  Response merger. The pending-read tag is delayed one stage to meet the port data.
  Unmapped and control reads return 8'hff.
  There is no back-pressure, so the host must take every response.
*/
`timescale 1ns/1ps

module snd_rsp_merge (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rd_pend_valid,
    input  snd_bus_pkg::port_id_t rd_pend_port,
    input  logic                  rd_pend_unmapped,
    input  snd_bus_pkg::data_t    rd_data [snd_bus_pkg::NUM_PORTS],
    output logic                  rsp_valid,
    output snd_bus_pkg::bus_rsp_t rsp
);

    logic                  tag_valid;
    snd_bus_pkg::port_id_t tag_port;
    logic                  tag_unmapped;

    // tag stage, aligned with the port read register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tag_valid <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            tag_valid <= rd_pend_valid;
            rsp_valid <= tag_valid;
        end
    end

    always_ff @(posedge clk) begin
        tag_port     <= rd_pend_port;
        tag_unmapped <= rd_pend_unmapped;
        if (tag_valid) begin
            rsp.rdata <= tag_unmapped ? snd_bus_pkg::OPEN_BUS : rd_data[tag_port];
        end
    end

endmodule

//--- hw/snd_sel_decode.sv
/*
  Select decoder with the scrambled chip-select map.
  Strobes and the pending-read tag are registered one cycle after the pop.
  Counter changes from select 2 or 5 apply to the next popped request.
  Where two ports share a select in one map, the lower port number wins.
*/
`timescale 1ns/1ps

module snd_sel_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pop_valid,
    input  snd_bus_pkg::bus_req_t  pop_req,
    output snd_bus_pkg::port_acc_t port_acc [snd_bus_pkg::NUM_PORTS],
    output logic                   rd_pend_valid,
    output snd_bus_pkg::port_id_t  rd_pend_port,
    output logic                   rd_pend_unmapped
);

    // rows are counter values, columns are FM-A, FM-B, ADPCM, latch
    localparam snd_bus_pkg::sel_t SEL_MAP [4][snd_bus_pkg::NUM_PORTS] = '{
        '{3'd3, 3'd1, 3'd6, 3'd7},
        '{3'd6, 3'd7, 3'd1, 3'd4},
        '{3'd4, 3'd7, 3'd3, 3'd1},
        '{3'd4, 3'd1, 3'd7, 3'd6}
    };

    snd_bus_pkg::scram_t   scram;
    snd_bus_pkg::port_id_t hit_port;
    logic                  hit;
    logic                  is_count;
    logic                  is_clear;
    logic                  is_ctrl;

    assign is_count = (pop_req.sel == snd_bus_pkg::SEL_COUNT);
    assign is_clear = (pop_req.sel == snd_bus_pkg::SEL_CLEAR);
    assign is_ctrl  = is_count || is_clear;

    // first match from port 0 upward gives the priority
    always_comb begin
        hit      = 1'b0;
        hit_port = '0;
        for (int p = 0; p < snd_bus_pkg::NUM_PORTS; p++) begin
            if (!hit && !is_ctrl && (SEL_MAP[scram][p] == pop_req.sel)) begin
                hit      = 1'b1;
                hit_port = snd_bus_pkg::port_id_t'(p);
            end
        end
    end

    // scramble counter, stepped or cleared by any access to the control selects
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scram <= '0;
        end else if (pop_valid) begin
            if (is_count) begin
                scram <= scram + 2'd1;
            end else if (is_clear) begin
                scram <= '0;
            end
        end
    end

    // per-port strobes, at most one set per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int p = 0; p < snd_bus_pkg::NUM_PORTS; p++) begin
                port_acc[p] <= '0;
            end
        end else begin
            for (int p = 0; p < snd_bus_pkg::NUM_PORTS; p++) begin
                port_acc[p].valid <= pop_valid && hit
                                     && (hit_port == snd_bus_pkg::port_id_t'(p));
                port_acc[p].wr    <= pop_req.wr;
                port_acc[p].idx   <= pop_req.idx;
                port_acc[p].wdata <= pop_req.wdata;
            end
        end
    end

    // tag for the response merger, one per read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_pend_valid    <= 1'b0;
            rd_pend_port     <= '0;
            rd_pend_unmapped <= 1'b0;
        end else begin
            rd_pend_valid    <= pop_valid && !pop_req.wr;
            rd_pend_port     <= hit_port;
            // control selects never hit, so they read as open bus too
            rd_pend_unmapped <= !hit;
        end
    end

endmodule

//--- project.f
hw/snd_bus_pkg.sv
hw/snd_req_fifo.sv
hw/snd_sel_decode.sv
hw/snd_chip_port.sv
hw/snd_rsp_merge.sv
hw/snd_bus_top.sv
tests/snd_bus_assert.sv
tests/snd_bus_tb.sv

//--- tests/snd_bus_assert.sv
/*
  Bound checks on the sound bus top: host credit use, one-hot port strobes
  and quiet outputs while reset is held.
*/
`timescale 1ns/1ps

module snd_bus_assert #(
    parameter int FIFO_DEPTH = 4
) (
    input logic                   clk,
    input logic                   rst,
    input logic                   req_valid,
    input logic                   credit_ret,
    input logic                   rsp_valid,
    input snd_bus_pkg::port_acc_t port_acc [snd_bus_pkg::NUM_PORTS]
);

    int                                outstanding;
    logic [snd_bus_pkg::NUM_PORTS-1:0] strobes;
    // failed assertions so far
    int                                fail_cnt;

    initial begin
        fail_cnt = 0;
    end

    always_comb begin
        for (int p = 0; p < snd_bus_pkg::NUM_PORTS; p++) begin
            strobes[p] = port_acc[p].valid;
        end
    end

    // requests accepted minus credits given back
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(req_valid) - int'(credit_ret);
        end
    end

    credit_limit: assert property (@(posedge clk) disable iff (rst)
        (outstanding >= 0) && (outstanding <= FIFO_DEPTH))
        else begin
            fail_cnt++;
            $error("host holds more requests in flight than it has credits");
        end

    strobe_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(strobes))
        else begin
            fail_cnt++;
            $error("more than one chip port strobed in one cycle");
        end

    reset_quiet: assert property (@(posedge clk) rst |-> (!rsp_valid && !credit_ret))
        else begin
            fail_cnt++;
            $error("rsp_valid or credit_ret active during reset");
        end

endmodule

bind snd_bus_top snd_bus_assert #(
    .FIFO_DEPTH (FIFO_DEPTH)
) u_bus_assert (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .credit_ret (credit_ret),
    .rsp_valid  (rsp_valid),
    .port_acc   (port_acc)
);

//--- tests/snd_bus_tb.sv
/*
  Testbench for the sound bus I/O side. A random host spends credits and checks
  every read response against a model of the scramble counter and the port registers.
  Inputs change on the falling edge and outputs are sampled there too.
*/
`timescale 1ns/1ps

module snd_bus_tb;

    localparam int NUM_RANDOM   = 600;
    // four maps of 16 writes, 16 reads and one step, then four control and unmapped reads
    localparam int NUM_DIRECTED = 4 * 33 + 4;
    localparam int CYCLE_LIMIT  = (NUM_RANDOM + NUM_DIRECTED) * 4 + 100;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    snd_bus_pkg::bus_req_t req;
    logic                  credit_ret;
    logic                  rsp_valid;
    snd_bus_pkg::bus_rsp_t rsp;

    // reference model state
    snd_bus_pkg::scram_t m_scram;
    snd_bus_pkg::data_t  image [4][4];
    snd_bus_pkg::data_t  exp_q [$];

    int depth;
    int sent;
    int returned;
    int rsp_cnt;
    int mismatch_cnt;
    int protocol_cnt;
    int cycle_cnt;

    snd_bus_top u_snd_bus_top (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .credit_ret (credit_ret),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    always #10 clk = ~clk;

    // selects per map, columns FM-A, FM-B, ADPCM, latch
    function automatic snd_bus_pkg::sel_t map_sel(input snd_bus_pkg::scram_t cnt, input int port);
        snd_bus_pkg::sel_t [3:0] row;
        case (cnt)
            2'd0:    row = {3'd7, 3'd6, 3'd1, 3'd3};
            2'd1:    row = {3'd4, 3'd1, 3'd7, 3'd6};
            2'd2:    row = {3'd1, 3'd3, 3'd7, 3'd4};
            default: row = {3'd6, 3'd7, 3'd1, 3'd4};
        endcase
        return row[port];
    endfunction

    // lowest port claiming the select, -1 when none does
    function automatic int find_port(input snd_bus_pkg::scram_t cnt, input snd_bus_pkg::sel_t sel);
        for (int p = 0; p < 4; p++) begin
            if (map_sel(cnt, p) == sel) begin
                return p;
            end
        end
        return -1;
    endfunction

    task automatic apply_model(input snd_bus_pkg::bus_req_t r);
        int p;
        if (r.sel == 3'd2) begin
            if (!r.wr) begin
                exp_q.push_back(8'hff);
            end
            m_scram = m_scram + 2'd1;
        end else if (r.sel == 3'd5) begin
            if (!r.wr) begin
                exp_q.push_back(8'hff);
            end
            m_scram = 2'd0;
        end else begin
            p = find_port(m_scram, r.sel);
            if (p < 0) begin
                if (!r.wr) begin
                    exp_q.push_back(8'hff);
                end
            end else if (r.wr) begin
                image[p][r.idx] = r.wdata;
            end else begin
                exp_q.push_back(image[p][r.idx]);
            end
        end
    endtask

    task automatic check_rsp(input snd_bus_pkg::data_t got, input snd_bus_pkg::data_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t: response %0d read %h, expected %h",
                     $time, rsp_cnt, got, exp);
        end
    endtask

    task automatic check_credit(input integer got, input integer exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t: %0d credits returned, %0d requests sent",
                     $time, got, exp);
        end
    endtask

    // advance to the next falling edge and collect credits and responses
    task automatic step_cycle();
        @(negedge clk);
        if (credit_ret) begin
            returned++;
        end
        if (rsp_valid) begin
            rsp_cnt++;
            if (exp_q.size() == 0) begin
                protocol_cnt++;
                $display("a response arrived at %0t with no read outstanding", $time);
            end else begin
                check_rsp(rsp.rdata, exp_q.pop_front());
            end
        end
    endtask

    task automatic idle_cycle();
        step_cycle();
        req_valid = 1'b0;
    endtask

    // waits for a credit, then drives one request for a single cycle
    task automatic send_req(input logic wr, input snd_bus_pkg::sel_t sel,
                            input snd_bus_pkg::reg_idx_t idx, input snd_bus_pkg::data_t wdata);
        snd_bus_pkg::bus_req_t r;
        step_cycle();
        while (sent - returned >= depth) begin
            req_valid = 1'b0;
            step_cycle();
        end
        r.wr      = wr;
        r.sel     = sel;
        r.idx     = idx;
        r.wdata   = wdata;
        req       = r;
        req_valid = 1'b1;
        sent++;
        apply_model(r);
    endtask

    task automatic drain_bus();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || returned != sent) && waited < 20) begin
            idle_cycle();
            waited++;
        end
        // extra cycles let stray responses or credits show up
        repeat (4) begin
            idle_cycle();
        end
        if (exp_q.size() != 0) begin
            protocol_cnt++;
            $display("%0d read responses never arrived", exp_q.size());
        end
        check_credit(returned, sent);
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d protocol errors, %0d assertion failures, %0d requests, %0d responses",
                 mismatch_cnt, protocol_cnt, u_snd_bus_top.u_bus_assert.fail_cnt,
                 sent, rsp_cnt);
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d reads still pending", cycle_cnt, exp_q.size());
            report_counts();
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int                     burst;
        int                     gap;
        int                     left;
        logic                   wr_r;
        snd_bus_pkg::sel_t      sel_r;
        snd_bus_pkg::reg_idx_t  idx_r;
        snd_bus_pkg::data_t     data_r;

        clk          = 1'b0;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        sent         = 0;
        returned     = 0;
        rsp_cnt      = 0;
        mismatch_cnt = 0;
        protocol_cnt = 0;
        cycle_cnt    = 0;
        m_scram      = 2'd0;
        for (int p = 0; p < 4; p++) begin
            for (int i = 0; i < 4; i++) begin
                image[p][i] = 8'h00;
            end
        end
        void'($urandom(32'hf77d));
        depth = u_snd_bus_top.FIFO_DEPTH;

        repeat (3) @(negedge clk);
        rst = 1'b0;

        // walk all four maps, every port register written then read back
        for (int m = 0; m < 4; m++) begin
            for (int p = 0; p < 4; p++) begin
                for (int i = 0; i < 4; i++) begin
                    send_req(1'b1, map_sel(m_scram, p), snd_bus_pkg::reg_idx_t'(i),
                             snd_bus_pkg::data_t'($urandom));
                end
            end
            for (int p = 0; p < 4; p++) begin
                for (int i = 0; i < 4; i++) begin
                    send_req(1'b0, map_sel(m_scram, p), snd_bus_pkg::reg_idx_t'(i), 8'h00);
                end
            end
            send_req(1'b1, 3'd2, 2'd0, 8'h00);
        end

        // map 0 again after the wrap; control reads step and clear the counter
        send_req(1'b1, 3'd2, 2'd1, 8'h5a);
        send_req(1'b0, 3'd2, 2'd2, 8'h00);
        send_req(1'b0, 3'd5, 2'd3, 8'h00);
        // select 4 is unmapped in map 0
        send_req(1'b0, 3'd4, 2'd0, 8'h00);
        drain_bus();

        // random host, bursts of up to FIFO_DEPTH back-to-back requests
        left = NUM_RANDOM;
        while (left > 0) begin
            burst = $urandom_range(depth, 1);
            if (burst > left) begin
                burst = left;
            end
            repeat (burst) begin
                wr_r   = logic'($urandom_range(1, 0));
                sel_r  = snd_bus_pkg::sel_t'($urandom_range(7, 0));
                idx_r  = snd_bus_pkg::reg_idx_t'($urandom_range(3, 0));
                data_r = snd_bus_pkg::data_t'($urandom);
                send_req(wr_r, sel_r, idx_r, data_r);
                left--;
            end
            gap = $urandom_range(3, 0);
            repeat (gap) begin
                idle_cycle();
            end
        end
        drain_bus();

        report_counts();
        if (mismatch_cnt == 0 && protocol_cnt == 0
                && u_snd_bus_top.u_bus_assert.fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
